//--- src/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define DATA_WIDTH   32
`define REG_COUNT    32
`define OPCODE_WIDTH 6

// Opcode field values
`define OP_RTYPE 6'b000000
`define OP_ADDI  6'b001000
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_RESET 6'b111111

`define FUNCT_ADD 6'b100000

`endif

//--- src/cpuPkg.sv
`include "cpu_cfg.svh"

package cpuPkg;

    typedef logic [`DATA_WIDTH-1:0]        word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIndex_t;
    typedef logic [`OPCODE_WIDTH-1:0]      opcode_t;
    typedef logic [15:0]                   imm_t;

    typedef enum logic [2:0] {
        stateReset,
        stateFetch,
        stateDecode,
        stateExecute,
        stateWriteback
    } cpuState_t;

    typedef enum logic {
        aluAdd,
        aluSub
    } aluOp_t;

    // One step's worth of datapath controls
    typedef struct packed {
        logic   pcWrite;
        logic   pcBranch;
        logic   irWrite;
        logic   abWrite;
        logic   aluOutWrite;
        logic   regWrite;
        logic   regClear;
        logic   srcImm;
        logic   dstRt;
        aluOp_t aluOp;
    } control_t;

    typedef struct packed {
        regIndex_t dest;
        word_t     data;
        logic      overflow;
    } writeback_t;

endpackage

//--- src/controlFsm.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module controlFsm (
    input  logic             clock,
    input  logic             reset,
    input  cpuPkg::opcode_t  opcode,
    input  cpuPkg::opcode_t  funct,
    input  logic             zero,
    input  logic             instrValid,
    output logic             instrReady,
    output logic             wbValid,
    input  logic             wbReady,
    output cpuPkg::control_t control,
    output logic             opcodeError
);

    cpuPkg::cpuState_t state;
    cpuPkg::cpuState_t nextState;
    logic isAdd;
    logic isAddi;
    logic isBranch;
    logic isReset;
    logic isKnown;
    logic branchTaken;
    logic wbFire;

    // Instruction decode
    assign isAdd    = (opcode == `OP_RTYPE) && (funct == `FUNCT_ADD);
    assign isAddi   = (opcode == `OP_ADDI);
    assign isBranch = (opcode == `OP_BEQ) || (opcode == `OP_BNE);
    assign isReset  = (opcode == `OP_RESET);
    assign isKnown  = isAdd || isAddi || isBranch || isReset;

    // beq takes on equal operands, bne on unequal
    assign branchTaken = (opcode == `OP_BEQ) ? zero : !zero;

    assign instrReady = (state == cpuPkg::stateFetch);
    assign wbFire     = wbValid && wbReady;

    always_comb begin
        nextState     = state;
        control       = '0;
        control.aluOp = cpuPkg::aluAdd;
        case (state)
            cpuPkg::stateFetch: begin
                control.irWrite = instrValid;
                control.pcWrite = instrValid;
                if (instrValid) begin
                    nextState = cpuPkg::stateDecode;
                end
            end
            cpuPkg::stateDecode: begin
                // Operands latch while the ALU forms the branch target
                control.abWrite     = 1'b1;
                control.aluOutWrite = 1'b1;
                if (isReset) begin
                    nextState = cpuPkg::stateReset;
                end else if (isKnown) begin
                    nextState = cpuPkg::stateExecute;
                end else begin
                    nextState = cpuPkg::stateFetch;
                end
            end
            cpuPkg::stateExecute: begin
                if (isBranch) begin
                    // Target stays in the result register
                    control.aluOp    = cpuPkg::aluSub;
                    control.pcWrite  = branchTaken;
                    control.pcBranch = branchTaken;
                end else begin
                    control.aluOutWrite = 1'b1;
                    control.srcImm      = isAddi;
                end
                nextState = cpuPkg::stateWriteback;
            end
            cpuPkg::stateWriteback: begin
                control.dstRt    = isAddi;
                control.regWrite = wbFire;
                if (isBranch || wbFire) begin
                    nextState = cpuPkg::stateFetch;
                end
            end
            cpuPkg::stateReset: begin
                // Reset opcode clears registers and pc
                control.regClear = 1'b1;
                nextState        = cpuPkg::stateFetch;
            end
            default: begin
                nextState = cpuPkg::stateFetch;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= cpuPkg::stateFetch;
            wbValid     <= 1'b0;
            opcodeError <= 1'b0;
        end else begin
            state       <= nextState;
            opcodeError <= (state == cpuPkg::stateDecode) && !isKnown;
            if (state == cpuPkg::stateWriteback && !isBranch && !wbValid) begin
                wbValid <= 1'b1;
            end else if (wbFire) begin
                wbValid <= 1'b0;
            end
        end
    end

    wbOnlyInWriteback: assert property (@(posedge clock) disable iff (reset)
        wbValid |-> state == cpuPkg::stateWriteback);

    noAcceptDuringWb: assert property (@(posedge clock) disable iff (reset)
        !(instrReady && wbValid));

endmodule

//--- src/registerFile.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module registerFile (
    input  logic              clock,
    input  logic              reset,
    input  cpuPkg::regIndex_t readA,
    input  cpuPkg::regIndex_t readB,
    input  cpuPkg::regIndex_t writeIndex,
    input  logic              writeEnable,
    input  logic              clearAll,
    input  cpuPkg::word_t     writeData,
    output cpuPkg::word_t     dataA,
    output cpuPkg::word_t     dataB
);

    cpuPkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset || clearAll) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeIndex != '0) begin
            // Register 0 is never written, so it reads zero
            regs[writeIndex] <= writeData;
        end
    end

    assign dataA = regs[readA];
    assign dataB = regs[readB];

endmodule

//--- src/executeUnit.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module executeUnit (
    input  logic             clock,
    input  logic             reset,
    input  cpuPkg::control_t control,
    input  cpuPkg::word_t    dataA,
    input  cpuPkg::word_t    dataB,
    input  cpuPkg::imm_t     imm,
    input  cpuPkg::word_t    pc,
    output cpuPkg::word_t    result,
    output logic             zero,
    output logic             overflow
);

    localparam int immWidth = $bits(cpuPkg::imm_t);
    localparam int msb      = `DATA_WIDTH - 1;

    cpuPkg::word_t regA;
    cpuPkg::word_t regB;
    cpuPkg::word_t immExt;
    cpuPkg::word_t opA;
    cpuPkg::word_t opB;
    cpuPkg::word_t aluValue;
    logic aluOverflow;

    assign immExt = {{(`DATA_WIDTH - immWidth){imm[immWidth-1]}}, imm};

    // Decode step computes pc plus offset, later steps use A and B
    always_comb begin
        if (control.abWrite) begin
            opA = pc;
            opB = immExt << 2;
        end else begin
            opA = regA;
            opB = control.srcImm ? immExt : regB;
        end
    end

    assign aluValue = (control.aluOp == cpuPkg::aluSub) ? opA - opB : opA + opB;
    assign zero     = (aluValue == '0);

    // Signed overflow from operand and result signs
    always_comb begin
        if (control.aluOp == cpuPkg::aluSub) begin
            aluOverflow = (opA[msb] != opB[msb]) && (aluValue[msb] != opA[msb]);
        end else begin
            aluOverflow = (opA[msb] == opB[msb]) && (aluValue[msb] != opA[msb]);
        end
    end

    always_ff @(posedge clock) begin
        if (control.abWrite) begin
            regA <= dataA;
            regB <= dataB;
        end
        if (control.aluOutWrite) begin
            result <= aluValue;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (control.aluOutWrite) begin
            overflow <= aluOverflow;
        end
    end

endmodule

//--- src/programCounter.sv
`timescale 1ns/1ps

module programCounter (
    input  logic             clock,
    input  logic             reset,
    input  cpuPkg::control_t control,
    input  cpuPkg::word_t    branchTarget,
    input  logic             resetPc,
    output cpuPkg::word_t    pc
);

    always_ff @(posedge clock) begin
        if (reset || resetPc) begin
            pc <= '0;
        end else if (control.pcWrite) begin
            if (control.pcBranch) begin
                pc <= branchTarget;
            end else begin
                pc <= pc + cpuPkg::word_t'(4);
            end
        end
    end

    // Targets are pc plus a multiple of four
    pcAligned: assert property (@(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

//--- src/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic               clock,
    input  logic               reset,
    input  logic               instrValid,
    output logic               instrReady,
    input  cpuPkg::word_t      instr,
    output logic               wbValid,
    input  logic               wbReady,
    output cpuPkg::writeback_t wb,
    output cpuPkg::word_t      pc,
    output logic               opcodeError
);

    cpuPkg::word_t     instrReg;
    cpuPkg::control_t  control;
    cpuPkg::opcode_t   opcode;
    cpuPkg::opcode_t   funct;
    cpuPkg::regIndex_t rs;
    cpuPkg::regIndex_t rt;
    cpuPkg::regIndex_t rd;
    cpuPkg::regIndex_t destIndex;
    cpuPkg::imm_t      imm;
    cpuPkg::word_t     dataA;
    cpuPkg::word_t     dataB;
    cpuPkg::word_t     result;
    logic zero;
    logic overflow;

    always_ff @(posedge clock) begin
        if (control.irWrite) begin
            instrReg <= instr;
        end
    end

    // Instruction fields
    assign opcode = instrReg[31:26];
    assign rs     = instrReg[25:21];
    assign rt     = instrReg[20:16];
    assign rd     = instrReg[15:11];
    assign imm    = instrReg[15:0];
    assign funct  = instrReg[5:0];

    assign destIndex = control.dstRt ? rt : rd;
    assign wb        = '{dest: destIndex, data: result, overflow: overflow};

    controlFsm fsm (
        .clock(clock), .reset(reset), .opcode(opcode), .funct(funct), .zero(zero),
        .instrValid(instrValid), .instrReady(instrReady), .wbValid(wbValid),
        .wbReady(wbReady), .control(control), .opcodeError(opcodeError)
    );

    registerFile regs (
        .clock(clock), .reset(reset), .readA(rs), .readB(rt), .writeIndex(destIndex),
        .writeEnable(control.regWrite), .clearAll(control.regClear),
        .writeData(result), .dataA(dataA), .dataB(dataB)
    );

    executeUnit exec (
        .clock(clock), .reset(reset), .control(control), .dataA(dataA), .dataB(dataB),
        .imm(imm), .pc(pc), .result(result), .zero(zero), .overflow(overflow)
    );

    programCounter pcUnit (
        .clock(clock), .reset(reset), .control(control), .branchTarget(result),
        .resetPc(control.regClear), .pc(pc)
    );

endmodule

//--- verif/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpuTb;

    localparam int timeoutCycles = 50;

    logic               clock;
    logic               reset;
    logic               instrValid;
    logic               instrReady;
    cpuPkg::word_t      instr;
    logic               wbValid;
    logic               wbReady;
    cpuPkg::writeback_t wb;
    cpuPkg::word_t      pc;
    logic               opcodeError;

    // Reference state of the core
    cpuPkg::word_t modelRegs [`REG_COUNT];
    cpuPkg::word_t modelPc;
    logic          errorSeen;

    cpuTop DUT (
        .clock(clock), .reset(reset), .instrValid(instrValid), .instrReady(instrReady),
        .instr(instr), .wbValid(wbValid), .wbReady(wbReady), .wb(wb), .pc(pc),
        .opcodeError(opcodeError)
    );

    always #10 clock = ~clock;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkWriteback(input string name, input cpuPkg::writeback_t actual,
                                  input cpuPkg::writeback_t expected);
        if (actual !== expected) begin
            failRun($sformatf("MISMATCH at %0t: %s got %0d/%h/%b, expected %0d/%h/%b",
                $time, name, actual.dest, actual.data, actual.overflow,
                expected.dest, expected.data, expected.overflow));
        end
    endtask

    task automatic checkPc(input string name, input cpuPkg::word_t actual,
                           input cpuPkg::word_t expected);
        if (actual !== expected) begin
            failRun($sformatf("MISMATCH at %0t: %s got %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    task automatic checkFlag(input string name, input bit actual, input bit expected);
        if (actual !== expected) begin
            failRun($sformatf("MISMATCH at %0t: %s got %b, expected %b",
                $time, name, actual, expected));
        end
    endtask

    // Polled on falling edges; also collects any opcodeError pulse
    task automatic waitInstrReady();
        int cycles = 0;
        while (!instrReady) begin
            if (wbValid) begin
                failRun("Writeback raised for an instruction that writes no register");
            end
            errorSeen = errorSeen | opcodeError;
            cycles++;
            if (cycles > timeoutCycles) begin
                failRun("Timed out waiting for instrReady");
            end
            @(negedge clock);
        end
        errorSeen = errorSeen | opcodeError;
    endtask

    task automatic waitWbValid();
        int cycles = 0;
        while (!wbValid) begin
            if (instrReady) begin
                failRun("Core returned to fetch without a writeback");
            end
            errorSeen = errorSeen | opcodeError;
            cycles++;
            if (cycles > timeoutCycles) begin
                failRun("Timed out waiting for wbValid");
            end
            @(negedge clock);
        end
    endtask

    // Random stall before taking the result
    task automatic acceptWriteback(output cpuPkg::writeback_t got);
        cpuPkg::writeback_t held;
        int idleCycles;
        held = wb;
        idleCycles = $urandom % 4;
        repeat (idleCycles) begin
            @(negedge clock);
            if (!wbValid || instrReady) begin
                failRun("Writeback dropped or instruction accepted while wbReady was low");
            end
            checkWriteback("wb while stalled", wb, held);
        end
        wbReady = 1'b1;
        @(posedge clock);
        @(negedge clock);
        wbReady = 1'b0;
        if (wbValid) begin
            failRun("wbValid stayed high after the writeback was taken");
        end
        got = held;
    endtask

    task automatic sendInstr(input cpuPkg::word_t word);
        waitInstrReady();
        instr      = word;
        instrValid = 1'b1;
        @(posedge clock);
        @(negedge clock);
        instrValid = 1'b0;
        errorSeen  = 1'b0;
    endtask

    task automatic runCase(input string kind, input cpuPkg::word_t word,
                           input cpuPkg::word_t expected);
        cpuPkg::regIndex_t  rs;
        cpuPkg::regIndex_t  rt;
        cpuPkg::word_t      offset;
        cpuPkg::word_t      operandB;
        cpuPkg::word_t      modelValue;
        longint             wideSum;
        cpuPkg::writeback_t want;
        cpuPkg::writeback_t got;
        rs       = word[25:21];
        rt       = word[20:16];
        offset   = {{16{word[15]}}, word[15:0]};
        want     = '0;
        modelPc  = modelPc + 4;
        if (kind == "wb") begin
            operandB   = (word[31:26] == `OP_ADDI) ? offset : modelRegs[rt];
            modelValue = modelRegs[rs] + operandB;
            wideSum    = longint'(signed'(modelRegs[rs])) + longint'(signed'(operandB));
            want.dest  = (word[31:26] == `OP_ADDI) ? rt : cpuPkg::regIndex_t'(word[15:11]);
            want.data  = expected;
            // Overflow when the wide sum does not fit a signed word
            want.overflow = (wideSum != longint'(signed'(modelValue)));
            if (want.dest != '0) begin
                modelRegs[want.dest] = modelValue;
            end
        end else if (kind == "br") begin
            if ((modelRegs[rs] == modelRegs[rt]) == (word[31:26] == `OP_BEQ)) begin
                modelPc = modelPc + (offset << 2);
            end
            modelValue = modelPc;
        end else if (kind == "rst") begin
            modelPc = '0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                modelRegs[i] = '0;
            end
            modelValue = modelPc;
        end else if (kind == "err") begin
            modelValue = 32'd1;
        end else begin
            failRun($sformatf("Unknown case kind %s", kind));
        end
        if (modelValue !== expected) begin
            failRun($sformatf("Case file value %h for instruction %h disagrees with model %h",
                expected, word, modelValue));
        end

        sendInstr(word);
        if (kind == "wb") begin
            waitWbValid();
            acceptWriteback(got);
            checkWriteback("wb", got, want);
        end else begin
            waitInstrReady();
        end
        checkFlag("opcodeError", errorSeen, kind == "err");
        checkPc("pc", pc, modelPc);
    endtask

    initial begin
        int            fd;
        int            fields;
        int            caseCount;
        string         line;
        string         kind;
        cpuPkg::word_t word;
        cpuPkg::word_t expected;
        clock      = 1'b0;
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        wbReady    = 1'b0;
        errorSeen  = 1'b0;
        modelPc    = '0;
        caseCount  = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        void'($urandom(43));
        fd = $fopen("verif/cpu_cases.txt", "r");
        if (fd == 0) begin
            failRun("Cannot open verif/cpu_cases.txt");
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h", kind, word, expected);
            if (fields != 3) begin
                failRun($sformatf("Malformed case line: %s", line));
            end
            runCase(kind, word, expected);
            caseCount++;
        end
        $fclose(fd);

        if (caseCount == 0) begin
            failRun("No cases were read from the case file");
        end else begin
            $display("%0d cases checked", caseCount);
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- verif/cpu_cases.txt
# kind instr expected: wb = register result, br and rst = pc afterwards, err = error flag
# all values hex, text after the third column is ignored
wb  20018000 ffff8000  addi r1, r0, -32768
wb  20020005 00000005  addi r2, r0, 5
wb  00221820 ffff8005  add r3, r1, r2
wb  2044ffff 00000004  addi r4, r2, -1
br  10420003 00000020  beq r2, r2, +3 taken
br  10220005 00000024  beq r1, r2, +5 not taken
br  1422fffe 00000020  bne r1, r2, -2 taken
br  14840007 00000024  bne r4, r4, +7 not taken
err 30000000 00000001  unknown opcode
err 00221822 00000001  unknown funct
wb  20400007 0000000c  addi r0, r2, 7 discarded
wb  00022820 00000005  add r5, r0, r2
wb  00210820 ffff0000  add r1, r1, r1
wb  00210820 fffe0000
wb  00210820 fffc0000
wb  00210820 fff80000
wb  00210820 fff00000
wb  00210820 ffe00000
wb  00210820 ffc00000
wb  00210820 ff800000
wb  00210820 ff000000
wb  00210820 fe000000
wb  00210820 fc000000
wb  00210820 f8000000
wb  00210820 f0000000
wb  00210820 e0000000
wb  00210820 c0000000
wb  00210820 80000000
wb  00232020 7fff8005  add r4, r1, r3 overflows
rst fc000000 00000000  reset opcode
wb  00232820 00000000  add r5, r1, r3 after clear

//--- tb.f
+incdir+src
src/cpuPkg.sv
src/controlFsm.sv
src/registerFile.sv
src/executeUnit.sv
src/programCounter.sv
src/cpuTop.sv
verif/cpuTb.sv

//--- Makefile
SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)

obj_dir/VcpuTb: tb.f $(SOURCES)
	verilator --binary --timing --assert --top-module cpuTb -f tb.f

.PHONY: run clean

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null

clean:
	rm -rf obj_dir
